// ==== build.f ====
+incdir+common
common/cpu_pkg.sv
common/cpu_ctrl_if.sv
cpu/cpu_alu.sv
cpu/cpu_regfile.sv
cpu/cpu_control.sv
cpu/cpu_bus_unit.sv
cpu/cpu_top.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

// ==== common/cpu_ctrl_if.sv ====
`timescale 1ns/1ps

interface cpu_ctrl_if;

    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::b_src_t   b_src;
    cpu_pkg::reg_sel_t rd_sel;
    cpu_pkg::reg_sel_t wr_sel;
    logic              wr_en;
    logic              flags_we;
    cpu_pkg::bus_op_t  bus_op;
    cpu_pkg::pc_act_t  pc_act;
    logic              m_last;   // Current machine cycle ends the instruction
    logic [1:0]        t_phase;  // Comes back from the bus unit

    modport ctrl (
        output alu_op, b_src, rd_sel, wr_sel, wr_en, flags_we,
        output bus_op, pc_act, m_last,
        input  t_phase
    );

    modport dp (
        input  alu_op, b_src, rd_sel, wr_sel, wr_en, flags_we,
        input  bus_op, pc_act, m_last,
        output t_phase
    );

endinterface

// ==== common/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Bus widths
`define CPU_ADDR_W   16
`define CPU_DATA_W   8

// Address of the first opcode fetch after reset
`define CPU_RESET_PC 16'h0000

// Clocks in one machine cycle (T0..T3)
`define CPU_T_PER_M  4

`endif

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    // Low three codes follow the opcode ALU field
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_ADC    = 4'd1,
        ALU_SUB    = 4'd2,
        ALU_SBC    = 4'd3,
        ALU_AND    = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_OR     = 4'd6,
        ALU_CP     = 4'd7,
        ALU_INC    = 4'd8,
        ALU_DEC    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_t;

    typedef struct packed {
        logic z;
        logic c;
    } flags_t;

    // Five bus operations need three bits
    typedef enum logic [2:0] {
        BUS_IDLE,
        BUS_FETCH,   // Opcode read at PC
        BUS_IMM,     // Immediate read at PC
        BUS_MEM_RD,  // Data read at HL
        BUS_MEM_WR   // Data write at HL
    } bus_op_t;

    // Register field encoding of the opcode
    typedef enum logic [2:0] {
        REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_HL_MEM, REG_A
    } reg_sel_t;

    typedef enum logic [1:0] {
        B_REG,
        B_IMM,
        B_MEM
    } b_src_t;

    typedef enum logic [1:0] {
        PC_HOLD,
        PC_INC,
        PC_LOAD_ABS,  // 16-bit immediate
        PC_ADD_REL    // Signed 8-bit offset
    } pc_act_t;

endpackage

// ==== cpu/cpu_alu.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_alu (
    input  cpu_pkg::alu_op_t       op,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  cpu_pkg::flags_t        flags_in,
    output logic [`CPU_DATA_W-1:0] result,
    output cpu_pkg::flags_t        flags_out
);

    localparam logic [`CPU_DATA_W-1:0] ONE = 1;

    logic                   carry_in;
    logic [`CPU_DATA_W:0]   carry_ext;
    logic [`CPU_DATA_W:0]   wide;       // Top bit is carry or borrow
    logic [`CPU_DATA_W-1:0] calc;

    assign carry_in  = (op == cpu_pkg::ALU_ADC || op == cpu_pkg::ALU_SBC) ? flags_in.c : 1'b0;
    assign carry_ext = {{`CPU_DATA_W{1'b0}}, carry_in};

    always_comb begin
        wide      = '0;
        calc      = b;
        flags_out = flags_in;
        case (op)
            cpu_pkg::ALU_ADD, cpu_pkg::ALU_ADC: begin
                wide        = {1'b0, a} + {1'b0, b} + carry_ext;
                calc        = wide[`CPU_DATA_W-1:0];
                flags_out.c = wide[`CPU_DATA_W];
            end
            cpu_pkg::ALU_SUB, cpu_pkg::ALU_SBC, cpu_pkg::ALU_CP: begin
                wide        = {1'b0, a} - {1'b0, b} - carry_ext;
                calc        = wide[`CPU_DATA_W-1:0];
                flags_out.c = wide[`CPU_DATA_W];  // Borrow
            end
            cpu_pkg::ALU_AND: begin
                calc        = a & b;
                flags_out.c = 1'b0;
            end
            cpu_pkg::ALU_XOR: begin
                calc        = a ^ b;
                flags_out.c = 1'b0;
            end
            cpu_pkg::ALU_OR: begin
                calc        = a | b;
                flags_out.c = 1'b0;
            end
            // INC and DEC work on the B operand and keep C
            cpu_pkg::ALU_INC: calc = b + ONE;
            cpu_pkg::ALU_DEC: calc = b - ONE;
            default:          calc = b;           // PASS_B
        endcase
        flags_out.z = (calc == '0);
    end

    // CP leaves A as it was
    assign result = (op == cpu_pkg::ALU_CP) ? a : calc;

endmodule

// ==== cpu/cpu_bus_unit.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_bus_unit (
    input  logic                   clk,
    input  logic                   rst,
    cpu_ctrl_if.dp                 ctrl,
    input  logic [`CPU_DATA_W-1:0] wr_data,
    input  logic [`CPU_ADDR_W-1:0] hl,
    output logic [`CPU_DATA_W-1:0] opcode,
    output logic [`CPU_ADDR_W-1:0] imm16,
    output logic [`CPU_DATA_W-1:0] mem_data,
    output logic [`CPU_ADDR_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] dout,
    input  logic [`CPU_DATA_W-1:0] din,
    output logic                   rd,
    output logic                   wr,
    output logic                   phi
);

    localparam logic [1:0] T0 = 2'd0;
    localparam logic [1:0] T2 = 2'd2;
    localparam logic [1:0] T3 = 2'(`CPU_T_PER_M - 1);
    localparam logic [`CPU_ADDR_W-1:0] PC_STEP = 1;

    logic [1:0]             phase;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_ADDR_W-1:0] rel;     // Sign-extended JR offset
    logic                   is_read;
    logic                   imm_hi;  // Next immediate byte is the high one

    assign ctrl.t_phase = phase;

    assign is_read = ctrl.bus_op inside {cpu_pkg::BUS_FETCH, cpu_pkg::BUS_IMM,
                                         cpu_pkg::BUS_MEM_RD};
    assign addr    = (ctrl.bus_op == cpu_pkg::BUS_MEM_RD ||
                      ctrl.bus_op == cpu_pkg::BUS_MEM_WR) ? hl : pc;
    assign rel     = {{(`CPU_ADDR_W-8){imm16[7]}}, imm16[7:0]};

    //////////////////////////////////////////////////////////////////////
    // Phase counter and bus strobes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= T0;
            a     <= `CPU_RESET_PC;
            rd    <= 1'b0;
            wr    <= 1'b0;
            phi   <= 1'b0;
        end else begin
            phase <= (phase == T3) ? T0 : phase + 2'd1;
            case (phase)
                T0: begin                 // Address out
                    a   <= addr;
                    rd  <= is_read;
                    wr  <= 1'b0;
                    phi <= 1'b1;
                end
                T2: begin
                    rd  <= 1'b0;
                    wr  <= (ctrl.bus_op == cpu_pkg::BUS_MEM_WR);
                    phi <= 1'b0;
                end
                T3: begin                 // Bus idle
                    rd <= 1'b0;
                    wr <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // PC moves only at T3
    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= `CPU_RESET_PC;
            imm_hi <= 1'b0;
        end else begin
            if (phase == T2 && ctrl.bus_op == cpu_pkg::BUS_IMM)
                imm_hi <= 1'b1;
            if (phase == T3) begin
                if (ctrl.m_last)
                    imm_hi <= 1'b0;    // Next instruction starts at the low byte
                case (ctrl.pc_act)
                    cpu_pkg::PC_INC:      pc <= pc + PC_STEP;
                    cpu_pkg::PC_LOAD_ABS: pc <= imm16;
                    cpu_pkg::PC_ADD_REL:  pc <= pc + rel;
                    default: ;
                endcase
            end
        end
    end

    // Read data lands at T2, write data goes out at T2
    always_ff @(posedge clk) begin
        if (phase == T2) begin
            case (ctrl.bus_op)
                cpu_pkg::BUS_FETCH:  opcode <= din;
                cpu_pkg::BUS_IMM: begin
                    if (imm_hi)
                        imm16[`CPU_ADDR_W-1:`CPU_DATA_W] <= din;
                    else
                        imm16[`CPU_DATA_W-1:0] <= din;
                end
                cpu_pkg::BUS_MEM_RD: mem_data <= din;
                cpu_pkg::BUS_MEM_WR: dout     <= wr_data;
                default: ;
            endcase
        end
    end

endmodule

// ==== cpu/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
    input  logic            clk,
    input  logic            rst,
    cpu_ctrl_if.ctrl        ctrl,
    input  logic [7:0]      opcode,
    input  cpu_pkg::flags_t flags,
    output logic            done
);

    localparam logic [7:0] OP_HALT = 8'h76;

    logic [1:0]        m_cycle;
    logic              halted;
    logic              jr_taken;
    cpu_pkg::reg_sel_t dst;
    cpu_pkg::reg_sel_t src;
    cpu_pkg::alu_op_t  alu_field;

    assign dst       = cpu_pkg::reg_sel_t'(opcode[5:3]);
    assign src       = cpu_pkg::reg_sel_t'(opcode[2:0]);
    assign alu_field = cpu_pkg::alu_op_t'({1'b0, opcode[5:3]});

    // Only JR Z and JR NZ test a flag
    always_comb begin
        case (opcode)
            8'h20:   jr_taken = !flags.z;
            8'h28:   jr_taken = flags.z;
            default: jr_taken = 1'b1;  // Plain JR
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Decode opcode and machine cycle into the control word
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ctrl.alu_op   = cpu_pkg::ALU_PASS_B;
        ctrl.b_src    = cpu_pkg::B_REG;
        ctrl.rd_sel   = src;
        ctrl.wr_sel   = dst;
        ctrl.wr_en    = 1'b0;
        ctrl.flags_we = 1'b0;
        ctrl.bus_op   = cpu_pkg::BUS_IDLE;
        ctrl.pc_act   = cpu_pkg::PC_HOLD;
        ctrl.m_last   = 1'b1;
        if (!halted) begin
            // M0 is always the opcode fetch
            if (m_cycle == 2'd0) begin
                ctrl.bus_op = cpu_pkg::BUS_FETCH;
                ctrl.pc_act = cpu_pkg::PC_INC;
            end
            casez (opcode)
                8'b00???110: begin                    // LD r,d8
                    if (dst != cpu_pkg::REG_HL_MEM) begin
                        if (m_cycle == 2'd0) begin
                            ctrl.m_last = 1'b0;
                        end else begin
                            ctrl.bus_op = cpu_pkg::BUS_IMM;
                            ctrl.pc_act = cpu_pkg::PC_INC;
                            ctrl.b_src  = cpu_pkg::B_IMM;
                            ctrl.wr_en  = 1'b1;
                        end
                    end
                end
                8'b00???10?: begin                    // INC r / DEC r
                    if (dst != cpu_pkg::REG_HL_MEM) begin
                        ctrl.alu_op   = opcode[0] ? cpu_pkg::ALU_DEC : cpu_pkg::ALU_INC;
                        ctrl.rd_sel   = dst;
                        ctrl.wr_en    = 1'b1;
                        ctrl.flags_we = 1'b1;
                    end
                end
                8'h18, 8'h20, 8'h28: begin            // JR e8, JR Z/NZ,e8
                    if (m_cycle == 2'd0) begin
                        ctrl.m_last = 1'b0;
                    end else if (m_cycle == 2'd1) begin
                        ctrl.bus_op = cpu_pkg::BUS_IMM;
                        ctrl.pc_act = cpu_pkg::PC_INC;
                        ctrl.m_last = !jr_taken;
                    end else begin
                        ctrl.pc_act = cpu_pkg::PC_ADD_REL;
                    end
                end
                OP_HALT: ;                            // Halt flag set below
                8'b01??????: begin                    // LD r,r' and the (HL) forms
                    if (dst == cpu_pkg::REG_HL_MEM || src == cpu_pkg::REG_HL_MEM) begin
                        if (m_cycle == 2'd0) begin
                            ctrl.m_last = 1'b0;
                        end else if (dst == cpu_pkg::REG_HL_MEM) begin
                            ctrl.bus_op = cpu_pkg::BUS_MEM_WR;  // src passes through ALU
                        end else begin
                            ctrl.bus_op = cpu_pkg::BUS_MEM_RD;
                            ctrl.b_src  = cpu_pkg::B_MEM;
                            ctrl.wr_en  = 1'b1;
                        end
                    end else begin
                        ctrl.wr_en = 1'b1;
                    end
                end
                8'b10??????: begin                    // ALU A,r
                    if (src != cpu_pkg::REG_HL_MEM) begin
                        ctrl.alu_op   = alu_field;
                        ctrl.wr_sel   = cpu_pkg::REG_A;
                        ctrl.wr_en    = (alu_field != cpu_pkg::ALU_CP);
                        ctrl.flags_we = 1'b1;
                    end
                end
                8'b11???110: begin                    // ALU A,d8
                    if (m_cycle == 2'd0) begin
                        ctrl.m_last = 1'b0;
                    end else begin
                        ctrl.bus_op   = cpu_pkg::BUS_IMM;
                        ctrl.pc_act   = cpu_pkg::PC_INC;
                        ctrl.b_src    = cpu_pkg::B_IMM;
                        ctrl.alu_op   = alu_field;
                        ctrl.wr_sel   = cpu_pkg::REG_A;
                        ctrl.wr_en    = (alu_field != cpu_pkg::ALU_CP);
                        ctrl.flags_we = 1'b1;
                    end
                end
                8'hC3: begin                          // JP a16
                    if (m_cycle == 2'd0) begin
                        ctrl.m_last = 1'b0;
                    end else begin
                        ctrl.bus_op = cpu_pkg::BUS_IMM;
                        ctrl.pc_act = (m_cycle == 2'd2) ? cpu_pkg::PC_LOAD_ABS
                                                        : cpu_pkg::PC_INC;
                        ctrl.m_last = (m_cycle == 2'd2);
                    end
                end
                default: ;                            // NOP and anything unsupported
            endcase
        end
    end

    // Machine cycle advances at T3
    always_ff @(posedge clk) begin
        if (rst) begin
            m_cycle <= 2'd0;
            halted  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= halted;  // One clock behind
            if (ctrl.t_phase == 2'd3 && !halted) begin
                m_cycle <= ctrl.m_last ? 2'd0 : m_cycle + 2'd1;
                if (m_cycle == 2'd0 && opcode == OP_HALT)
                    halted <= 1'b1;
            end
        end
    end

endmodule

// ==== cpu/cpu_regfile.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_regfile (
    input  logic                     clk,
    input  logic                     rst,
    cpu_ctrl_if.dp                   ctrl,
    input  logic [`CPU_DATA_W-1:0]   wr_data,
    input  cpu_pkg::flags_t          flags_in,
    output logic [`CPU_DATA_W-1:0]   rd_data,
    output logic [`CPU_DATA_W-1:0]   acc,
    output logic [2*`CPU_DATA_W-1:0] hl,
    output cpu_pkg::flags_t          flags
);

    // Indexed by the opcode encoding, slot 6 stays zero
    logic [`CPU_DATA_W-1:0] regs [0:7];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
            flags <= '0;
        end else if (ctrl.t_phase == 2'd3) begin
            if (ctrl.wr_en && ctrl.wr_sel != cpu_pkg::REG_HL_MEM)
                regs[ctrl.wr_sel] <= wr_data;
            if (ctrl.flags_we)
                flags <= flags_in;
        end
    end

    // Read side
    assign rd_data = regs[ctrl.rd_sel];
    assign acc     = regs[cpu_pkg::REG_A];
    assign hl      = {regs[cpu_pkg::REG_H], regs[cpu_pkg::REG_L]};

endmodule

// ==== cpu/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`CPU_ADDR_W-1:0] a,
    output logic [`CPU_DATA_W-1:0] dout,
    input  logic [`CPU_DATA_W-1:0] din,
    output logic                   rd,
    output logic                   wr,
    output logic                   phi,
    output logic                   done
);

    cpu_ctrl_if ctrl_if ();

    logic [`CPU_DATA_W-1:0] opcode;
    logic [`CPU_ADDR_W-1:0] imm16;
    logic [`CPU_DATA_W-1:0] mem_data;
    logic [`CPU_DATA_W-1:0] rd_data;
    logic [`CPU_DATA_W-1:0] acc;
    logic [`CPU_ADDR_W-1:0] hl;
    logic [`CPU_DATA_W-1:0] alu_b;
    logic [`CPU_DATA_W-1:0] alu_result;
    cpu_pkg::flags_t        flags;
    cpu_pkg::flags_t        alu_flags;

    // ALU B operand, the immediate byte is the low half of imm16
    always_comb begin
        case (ctrl_if.b_src)
            cpu_pkg::B_IMM: alu_b = imm16[`CPU_DATA_W-1:0];
            cpu_pkg::B_MEM: alu_b = mem_data;
            default:        alu_b = rd_data;
        endcase
    end

    cpu_control control_i (
        .clk    (clk),
        .rst    (rst),
        .ctrl   (ctrl_if.ctrl),
        .opcode (opcode),
        .flags  (flags),
        .done   (done)
    );

    cpu_regfile regfile_i (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl_if.dp),
        .wr_data  (alu_result),
        .flags_in (alu_flags),
        .rd_data  (rd_data),
        .acc      (acc),
        .hl       (hl),
        .flags    (flags)
    );

    cpu_alu alu_i (
        .op        (ctrl_if.alu_op),
        .a         (acc),
        .b         (alu_b),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    cpu_bus_unit bus_i (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl_if.dp),
        .wr_data  (alu_result),   // Store data passes through the ALU
        .hl       (hl),
        .opcode   (opcode),
        .imm16    (imm16),
        .mem_data (mem_data),
        .a        (a),
        .dout     (dout),
        .din      (din),
        .rd       (rd),
        .wr       (wr),
        .phi      (phi)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module cpu_tb -o cpu_sim
./obj_dir/cpu_sim

// ==== verif/cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties (
    input logic clk,
    input logic rst,
    input logic rd,
    input logic wr,
    input logic phi,
    input logic done
);

    // Read and write strobes are exclusive
    assert property (@(posedge clk) disable iff (rst) !(rd && wr))
        else $error("rd and wr are high in the same cycle");

    // Write strobe comes at T2, two clocks after phi rose at T0
    assert property (@(posedge clk) disable iff (rst) $rose(wr) |-> $past($rose(phi), 2))
        else $error("wr rose outside the T2 slot");

    // Bus stays quiet once halted
    assert property (@(posedge clk) disable iff (rst) done |-> (!rd && !wr))
        else $error("bus strobe active after done");

endmodule

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

    localparam int          N_RAND  = 40;
    localparam int          N_INSTR = N_RAND + 8;  // LD H prelude, body, six stores, HALT
    localparam int          CLK_NS  = 40;
    localparam int          LIMIT   = N_INSTR * 3 * `CPU_T_PER_M + 50 + 20 * `CPU_T_PER_M;
    localparam logic [31:0] SEED    = 32'h65be3fbe;

    logic        clk;
    logic        rst;
    logic [15:0] a;
    logic [7:0]  dout;
    logic [7:0]  din;
    logic        rd;
    logic        wr;
    logic        phi;
    logic        done;

    logic [7:0]  mem [0:65535];
    logic [7:0]  model_mem [0:65535];
    logic [7:0]  model_reg [0:7];
    logic        mz;
    logic        mc;
    logic [15:0] exp_rd_q [$];
    logic [23:0] exp_wr_q [$];      // {address, data}
    int          kind [0:N_INSTR-1];
    logic [15:0] start_addr [0:N_INSTR];
    logic        prev_rd;
    logic        prev_wr;
    logic        done_seen;
    int          cycles_out_of_rst;

    cpu_top dut_i (
        .clk  (clk),
        .rst  (rst),
        .a    (a),
        .dout (dout),
        .din  (din),
        .rd   (rd),
        .wr   (wr),
        .phi  (phi),
        .done (done)
    );

    bind cpu_top cpu_properties props_i (
        .clk (clk), .rst (rst), .rd (rd), .wr (wr), .phi (phi), .done (done)
    );

    assign din = mem[a];  // Memory answers combinationally

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("ERROR at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("Test failures found");
        $fatal(1, "value mismatch");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program generator
    //////////////////////////////////////////////////////////////////////
    function automatic int instr_len(input int k);
        case (k)
            1, 6, 9, 10, 11: return 2;
            8:               return 3;
            default:         return 1;
        endcase
    endfunction

    // Any register but H and the (HL) slot
    function automatic logic [2:0] pick_dst();
        case ($urandom_range(0, 5))
            0:       return 3'd0;
            1:       return 3'd1;
            2:       return 3'd2;
            3:       return 3'd3;
            4:       return 3'd5;
            default: return 3'd7;
        endcase
    endfunction

    function automatic logic [2:0] pick_src();
        logic [2:0] s;
        s = 3'($urandom_range(0, 6));
        return (s == 3'd6) ? 3'd7 : s;
    endfunction

    // Short forward hop that never passes the store block
    function automatic int pick_target(input int i);
        int j;
        j = i + 1 + int'($urandom_range(0, 3));
        return (j > N_RAND + 1) ? N_RAND + 1 : j;
    endfunction

    task automatic build_program;
        logic [15:0] ad;
        logic [15:0] pc;
        logic [15:0] off;
        logic [7:0]  store_ops [0:5];
        int          j;
        store_ops = '{8'h77, 8'h70, 8'h71, 8'h72, 8'h73, 8'h75};
        for (int x = 0; x < 65536; x++) begin
            ad     = 16'(x);
            mem[x] = ad[7:0] ^ {ad[14:8], ad[15]} ^ 8'h5A;
        end
        kind[0] = 11;                            // LD H,80h keeps HL out of the code
        for (int i = 1; i <= N_RAND; i++)
            kind[i] = int'($urandom_range(0, 10));
        for (int i = N_RAND + 1; i < N_INSTR - 1; i++)
            kind[i] = 12;
        kind[N_INSTR-1] = 13;
        start_addr[0] = `CPU_RESET_PC;
        for (int i = 0; i < N_INSTR; i++)
            start_addr[i+1] = start_addr[i] + 16'(instr_len(kind[i]));
        for (int i = 0; i < N_INSTR; i++) begin
            pc = start_addr[i];
            case (kind[i])
                1:  begin
                    mem[pc]       = {2'b00, pick_dst(), 3'b110};
                    mem[pc+16'd1] = 8'($urandom);
                end
                2:  mem[pc] = {2'b01, pick_dst(), pick_src()};
                3:  mem[pc] = 8'h7E;
                4:  mem[pc] = 8'h77;
                5:  mem[pc] = {2'b10, 3'($urandom_range(0, 7)), pick_src()};
                6:  begin
                    mem[pc]       = {2'b11, 3'($urandom_range(0, 7)), 3'b110};
                    mem[pc+16'd1] = 8'($urandom);
                end
                7:  mem[pc] = {2'b00, pick_dst(), 2'b10, 1'($urandom_range(0, 1))};
                8:  begin
                    j             = pick_target(i);
                    mem[pc]       = 8'hC3;
                    mem[pc+16'd1] = start_addr[j][7:0];
                    mem[pc+16'd2] = start_addr[j][15:8];
                end
                9, 10: begin
                    j   = pick_target(i);
                    off = start_addr[j] - (pc + 16'd2);
                    if (kind[i] == 9)
                        mem[pc] = 8'h18;
                    else
                        mem[pc] = $urandom_range(0, 1) ? 8'h28 : 8'h20;
                    mem[pc+16'd1] = off[7:0];
                end
                11: begin
                    mem[pc]       = 8'h26;
                    mem[pc+16'd1] = 8'h80;
                end
                12: mem[pc] = store_ops[i-N_RAND-1];
                13: mem[pc] = 8'h76;
                default: mem[pc] = 8'h00;  // NOP
            endcase
        end
        for (int x = 0; x < 65536; x++)
            model_mem[x] = mem[x];
    endtask

    //////////////////////////////////////////////////////////////////////
    // Instruction-level model
    //////////////////////////////////////////////////////////////////////
    task automatic model_alu(input logic [2:0] op, input logic [7:0] b);
        logic [8:0] w;
        logic [7:0] res;
        logic       cin;
        cin = (op == 3'd1 || op == 3'd3) ? mc : 1'b0;
        case (op)
            3'd0, 3'd1: begin
                w   = {1'b0, model_reg[7]} + {1'b0, b} + {8'd0, cin};
                res = w[7:0];
                mc  = w[8];
            end
            3'd4: begin res = model_reg[7] & b; mc = 1'b0; end
            3'd5: begin res = model_reg[7] ^ b; mc = 1'b0; end
            3'd6: begin res = model_reg[7] | b; mc = 1'b0; end
            default: begin                       // SUB SBC CP
                res = model_reg[7] - b - {7'd0, cin};
                mc  = ({1'b0, b} + {8'd0, cin}) > {1'b0, model_reg[7]};
            end
        endcase
        mz = (res == 8'd0);
        if (op != 3'd7)
            model_reg[7] = res;
    endtask

    task automatic run_model;
        logic [15:0] pc;
        logic [15:0] hl;
        logic [7:0]  op;
        logic [7:0]  imm;
        logic [7:0]  hi;
        int          steps;
        pc    = `CPU_RESET_PC;
        mz    = 1'b0;
        mc    = 1'b0;
        steps = 0;
        for (int i = 0; i < 8; i++)
            model_reg[i] = 8'd0;
        forever begin
            steps++;
            if (steps > 1000)
                report_problem("model never reached HALT");
            hl = {model_reg[4], model_reg[5]};
            op = model_mem[pc];
            exp_rd_q.push_back(pc);
            pc++;
            if (op == 8'h76)
                break;
            casez (op)
                8'h00: ;
                8'b00???110: begin               // LD r,d8
                    exp_rd_q.push_back(pc);
                    model_reg[op[5:3]] = model_mem[pc];
                    pc++;
                end
                8'b00???10?: begin               // INC and DEC keep C
                    model_reg[op[5:3]] = op[0] ? model_reg[op[5:3]] - 8'd1
                                               : model_reg[op[5:3]] + 8'd1;
                    mz = (model_reg[op[5:3]] == 8'd0);
                end
                8'h18, 8'h20, 8'h28: begin
                    exp_rd_q.push_back(pc);
                    imm = model_mem[pc];
                    pc++;
                    if (op == 8'h18 || (op == 8'h28 && mz) || (op == 8'h20 && !mz))
                        pc = pc + {{8{imm[7]}}, imm};
                end
                8'hC3: begin
                    exp_rd_q.push_back(pc);
                    imm = model_mem[pc];
                    pc++;
                    exp_rd_q.push_back(pc);
                    hi = model_mem[pc];
                    pc = {hi, imm};
                end
                8'b01110???: begin               // LD (HL),r
                    exp_wr_q.push_back({hl, model_reg[op[2:0]]});
                    model_mem[hl] = model_reg[op[2:0]];
                end
                8'b01???110: begin               // LD r,(HL)
                    exp_rd_q.push_back(hl);
                    model_reg[op[5:3]] = model_mem[hl];
                end
                8'b01??????: model_reg[op[5:3]] = model_reg[op[2:0]];
                8'b10??????: model_alu(op[5:3], model_reg[op[2:0]]);
                8'b11???110: begin
                    exp_rd_q.push_back(pc);
                    model_alu(op[5:3], model_mem[pc]);
                    pc++;
                end
                default: report_problem("generator emitted an opcode the model lacks");
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus monitor sampled mid-cycle
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        logic [15:0] exp_a;
        logic [23:0] exp_w;
        if (rst) begin
            assert (!rd && !wr && !phi && !done)
                else report_problem("rd, wr, phi or done active during reset");
        end else begin
            cycles_out_of_rst++;
            if (cycles_out_of_rst == 1)
                assert (!rd && !wr && !phi && !done)
                    else report_problem("rd, wr, phi or done active right after reset");
            if (cycles_out_of_rst == 2) begin  // First T0 edge has passed
                assert (rd) else report_problem("first fetch missed the first T0 edge");
                assert (a == `CPU_RESET_PC) else report_mismatch("a", a, `CPU_RESET_PC);
            end
            if (rd && !prev_rd) begin
                assert (!done_seen) else report_problem("read after done");
                assert (exp_rd_q.size() > 0) else report_problem("read beyond the program");
                exp_a = exp_rd_q.pop_front();
                assert (a == exp_a) else report_mismatch("a", a, exp_a);
            end
            if (wr && !prev_wr) begin
                assert (!done_seen) else report_problem("write after done");
                assert (exp_wr_q.size() > 0) else report_problem("write the model did not make");
                exp_w = exp_wr_q.pop_front();
                assert (a == exp_w[23:8]) else report_mismatch("a", a, exp_w[23:8]);
                assert (dout == exp_w[7:0]) else report_mismatch("dout", dout, exp_w[7:0]);
                mem[a] = dout;
            end
            if (done_seen)
                assert (done) else report_problem("done fell before reset");
            if (done)
                done_seen = 1'b1;
        end
        prev_rd = rd;
        prev_wr = wr;
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("ERROR at %0t ns: watchdog expired before the program halted", $time);
        $display("Test failures found");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(SEED));
        rst               = 1'b1;
        prev_rd           = 1'b0;
        prev_wr           = 1'b0;
        done_seen         = 1'b0;
        cycles_out_of_rst = 0;
        build_program;
        run_model;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wait (done === 1'b1);
        // Quiet window after HALT
        repeat (20 * `CPU_T_PER_M) @(posedge clk);
        if (exp_rd_q.size() == 0 && exp_wr_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("ERROR at %0t ns: %0d reads and %0d writes never appeared", $time,
                     exp_rd_q.size(), exp_wr_q.size());
            $display("Test failures found");
            $fatal(1, "missing bus cycles");
        end
    end

endmodule
